// File: design/rv_pkg.sv
`default_nettype none

package rv_pkg;

	// okay response on any bus channel
	localparam logic [1:0] RESP_OKAY = 2'b00;

	// rv32i major opcodes
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B
	} rv_alu_op_e;

	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_LOAD,
		MEM_STORE
	} rv_mem_op_e;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_BEQ,
		BR_BNE,
		BR_BLT,
		BR_JAL
	} rv_br_e;

	// decoded instruction handed from decode to execute
	typedef struct packed {
		rv_alu_op_e  alu_op;
		rv_mem_op_e  mem_op;
		rv_br_e      br;
		logic        use_imm;
		logic [4:0]  rd;
		logic        wen;
		logic [31:0] imm;
		logic        halt;
	} rv_dec_t;

endpackage

`default_nettype wire

// File: design/rv_if.sv
`default_nettype none

// one fetched word on its way to decode
interface fetch_if;
	logic        valid;
	logic [31:0] pc;
	logic [31:0] inst;
	logic        fault;

	modport fetch (output valid, pc, inst, fault);
	modport decode (input valid, pc, inst, fault);
endinterface

// executed instruction waiting for memory and write-back
interface mem_req_if import rv_pkg::*; ();
	logic        valid;
	logic [31:0] pc;
	logic [31:0] next_pc;
	// alu value, or the address of a load or store
	logic [31:0] result;
	logic [31:0] store_data;
	logic [4:0]  rd;
	logic        wen;
	rv_mem_op_e  mem_op;
	logic        halt;

	modport exec (output valid, pc, next_pc, result, store_data, rd, wen, mem_op, halt);
	modport lsu (input valid, pc, next_pc, result, store_data, rd, wen, mem_op, halt);
endinterface

`default_nettype wire

// File: design/rv_fetch.sv
`default_nettype none

module rv_fetch import rv_pkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  wire         clock,
	input  wire         rst_i,

	output logic [31:0] inst_addr_o,
	output logic        inst_addr_valid_o,
	input  wire         inst_addr_ready_i,
	input  wire  [31:0] inst_data_i,
	input  wire  [1:0]  inst_resp_i,
	input  wire         inst_valid_i,
	output logic        inst_ready_o,

	input  wire         commit_i,
	input  wire  [31:0] commit_pc_i,
	input  wire         halt_i,

	fetch_if.fetch      f
);

	typedef enum logic [1:0] {
		S_ADDR,
		S_DATA,
		S_WAIT
	} state_e;

	state_e      state_q;
	logic [31:0] pc_q;
	// first fetch after reset needs no commit
	logic        boot_q;

	always_ff @(posedge clock) begin
		if (rst_i) begin
			state_q <= S_WAIT;
			pc_q    <= RESET_PC;
			boot_q  <= 1'b1;
			f.valid <= 1'b0;
		end else begin
			f.valid <= 1'b0;
			case (state_q)
				S_ADDR: begin
					if (inst_addr_ready_i)
						state_q <= S_DATA;
				end
				S_DATA: begin
					if (inst_valid_i) begin
						f.valid <= 1'b1;
						state_q <= S_WAIT;
					end
				end
				default: begin
					if ((boot_q || commit_i) && !halt_i) begin
						boot_q  <= 1'b0;
						state_q <= S_ADDR;
						if (commit_i)
							pc_q <= commit_pc_i;
					end
				end
			endcase
		end
	end

	// word and fault captured on the data handshake
	always_ff @(posedge clock) begin
		if (state_q == S_DATA && inst_valid_i) begin
			f.inst  <= inst_data_i;
			f.fault <= (inst_resp_i != RESP_OKAY);
		end
	end

	assign f.pc              = pc_q;
	assign inst_addr_o       = pc_q;
	assign inst_addr_valid_o = (state_q == S_ADDR);
	assign inst_ready_o      = (state_q == S_DATA);

	// one instruction in flight, so commit only arrives while fetch waits for it
	a_commit_in_wait: assert property (@(posedge clock) disable iff (rst_i)
		commit_i |-> state_q == S_WAIT && !boot_q);

endmodule

`default_nettype wire

// File: design/rv_regfile.sv
`default_nettype none

module rv_regfile (
	input  wire         clock,
	input  wire         rst_i,
	input  wire  [4:0]  raddr1_i,
	input  wire  [4:0]  raddr2_i,
	input  wire         wen_i,
	input  wire  [4:0]  waddr_i,
	input  wire  [31:0] wdata_i,
	output logic [31:0] rdata1_o,
	output logic [31:0] rdata2_o
);

	// x1..x31, x0 has no storage
	logic [31:0] regs_q [1:31];

	always_ff @(posedge clock) begin
		if (wen_i && waddr_i != 5'd0)
			regs_q[waddr_i] <= wdata_i;
	end

	assign rdata1_o = (raddr1_i == 5'd0) ? 32'd0 : regs_q[raddr1_i];
	assign rdata2_o = (raddr2_i == 5'd0) ? 32'd0 : regs_q[raddr2_i];

	// write-back control is cleared by the lsu reset
	a_no_write_in_reset: assert property (@(posedge clock)
		rst_i && $past(rst_i) |-> !wen_i);

endmodule

`default_nettype wire

// File: design/rv_decode.sv
`default_nettype none

module rv_decode import rv_pkg::*; (
	input  wire         clock,
	input  wire         rst_i,

	fetch_if.decode     f,

	output logic [4:0]  raddr1_o,
	output logic [4:0]  raddr2_o,
	input  wire  [31:0] rdata1_i,
	input  wire  [31:0] rdata2_i,

	output logic        dec_valid_o,
	output rv_dec_t     dec_o,
	output logic [31:0] pc_o,
	output logic [31:0] rs1_o,
	output logic [31:0] rs2_o
);

	logic        valid_q;
	logic [31:0] inst_q;
	logic [31:0] pc_q;
	logic        fault_q;
	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;

	always_ff @(posedge clock) begin
		if (rst_i)
			valid_q <= 1'b0;
		else
			valid_q <= f.valid;
	end

	always_ff @(posedge clock) begin
		if (f.valid) begin
			inst_q  <= f.inst;
			pc_q    <= f.pc;
			fault_q <= f.fault;
		end
	end

	assign opcode = inst_q[6:0];
	assign funct3 = inst_q[14:12];

	// immediates of each format
	assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
	assign imm_s = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
	assign imm_b = {{20{inst_q[31]}}, inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
	assign imm_u = {inst_q[31:12], 12'd0};
	assign imm_j = {{12{inst_q[31]}}, inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

	always_comb begin
		dec_o.alu_op  = ALU_ADD;
		dec_o.mem_op  = MEM_NONE;
		dec_o.br      = BR_NONE;
		dec_o.use_imm = 1'b0;
		dec_o.rd      = inst_q[11:7];
		dec_o.wen     = 1'b0;
		dec_o.imm     = imm_i;
		dec_o.halt    = 1'b0;
		case (opcode)
			OP_REG, OP_IMM: begin
				dec_o.wen     = 1'b1;
				dec_o.use_imm = (opcode == OP_IMM);
				case (funct3)
					3'b000: dec_o.alu_op = (opcode == OP_REG && inst_q[30]) ? ALU_SUB : ALU_ADD;
					3'b010: dec_o.alu_op = ALU_SLT;
					3'b100: dec_o.alu_op = ALU_XOR;
					3'b110: dec_o.alu_op = ALU_OR;
					3'b111: dec_o.alu_op = ALU_AND;
					default: dec_o.halt = 1'b1;
				endcase
				// multiply and other funct7 encodings
				if (opcode == OP_REG && (inst_q[31] || inst_q[29:25] != 5'd0))
					dec_o.halt = 1'b1;
			end
			OP_LUI: begin
				dec_o.wen     = 1'b1;
				dec_o.use_imm = 1'b1;
				dec_o.alu_op  = ALU_PASS_B;
				dec_o.imm     = imm_u;
			end
			OP_LOAD: begin
				dec_o.wen     = 1'b1;
				dec_o.use_imm = 1'b1;
				dec_o.mem_op  = MEM_LOAD;
				dec_o.halt    = (funct3 != 3'b010);
			end
			OP_STORE: begin
				dec_o.use_imm = 1'b1;
				dec_o.mem_op  = MEM_STORE;
				dec_o.imm     = imm_s;
				dec_o.halt    = (funct3 != 3'b010);
			end
			OP_BRANCH: begin
				dec_o.imm = imm_b;
				case (funct3)
					3'b000: dec_o.br = BR_BEQ;
					3'b001: dec_o.br = BR_BNE;
					3'b100: dec_o.br = BR_BLT;
					default: dec_o.halt = 1'b1;
				endcase
			end
			OP_JAL: begin
				dec_o.wen = 1'b1;
				dec_o.br  = BR_JAL;
				dec_o.imm = imm_j;
			end
			// ebreak and every other system op stop the core
			OP_SYSTEM: dec_o.halt = 1'b1;
			default: dec_o.halt = 1'b1;
		endcase
		// fetch fault behaves like an unknown opcode
		if (fault_q || dec_o.halt) begin
			dec_o.halt   = 1'b1;
			dec_o.wen    = 1'b0;
			dec_o.mem_op = MEM_NONE;
			dec_o.br     = BR_NONE;
		end
	end

	assign raddr1_o    = inst_q[19:15];
	assign raddr2_o    = inst_q[24:20];
	assign dec_valid_o = valid_q;
	assign pc_o        = pc_q;
	assign rs1_o       = rdata1_i;
	assign rs2_o       = rdata2_i;

endmodule

`default_nettype wire

// File: design/rv_execute.sv
`default_nettype none

module rv_execute import rv_pkg::*; (
	input  wire         clock,
	input  wire         rst_i,
	input  wire         dec_valid_i,
	input  wire rv_dec_t dec_i,
	input  wire  [31:0] pc_i,
	input  wire  [31:0] rs1_i,
	input  wire  [31:0] rs2_i,

	mem_req_if.exec     m
);

	logic [31:0] op_b;
	logic [31:0] alu_res;
	logic [31:0] pc_plus4;
	logic        taken;

	assign op_b     = dec_i.use_imm ? dec_i.imm : rs2_i;
	assign pc_plus4 = pc_i + 32'd4;

	always_comb begin
		case (dec_i.alu_op)
			ALU_ADD:  alu_res = rs1_i + op_b;
			ALU_SUB:  alu_res = rs1_i - op_b;
			ALU_AND:  alu_res = rs1_i & op_b;
			ALU_OR:   alu_res = rs1_i | op_b;
			ALU_XOR:  alu_res = rs1_i ^ op_b;
			ALU_SLT:  alu_res = {31'd0, $signed(rs1_i) < $signed(op_b)};
			default:  alu_res = op_b;
		endcase
	end

	// branch condition on the two source registers
	always_comb begin
		case (dec_i.br)
			BR_BEQ:  taken = (rs1_i == rs2_i);
			BR_BNE:  taken = (rs1_i != rs2_i);
			BR_BLT:  taken = ($signed(rs1_i) < $signed(rs2_i));
			BR_JAL:  taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst_i)
			m.valid <= 1'b0;
		else
			m.valid <= dec_valid_i;
	end

	// held until the next instruction arrives, which is after commit
	always_ff @(posedge clock) begin
		if (dec_valid_i) begin
			m.pc         <= pc_i;
			m.next_pc    <= taken ? pc_i + dec_i.imm : pc_plus4;
			m.result     <= (dec_i.br == BR_JAL) ? pc_plus4 : alu_res;
			m.store_data <= rs2_i;
			m.rd         <= dec_i.rd;
			m.wen        <= dec_i.wen;
			m.mem_op     <= dec_i.mem_op;
			m.halt       <= dec_i.halt;
		end
	end

endmodule

`default_nettype wire

// File: design/rv_lsu.sv
`default_nettype none

module rv_lsu import rv_pkg::*; (
	input  wire         clock,
	input  wire         rst_i,

	mem_req_if.lsu      m,

	output logic [31:0] data_raddr_o,
	output logic        data_raddr_valid_o,
	input  wire         data_raddr_ready_i,
	input  wire  [31:0] data_rdata_i,
	input  wire  [1:0]  data_rresp_i,
	input  wire         data_rvalid_i,
	output logic        data_rready_o,
	output logic [31:0] data_waddr_o,
	output logic        data_waddr_valid_o,
	input  wire         data_waddr_ready_i,
	output logic [31:0] data_wdata_o,
	output logic        data_wvalid_o,
	input  wire         data_wready_i,
	input  wire  [1:0]  data_bresp_i,
	input  wire         data_bvalid_i,
	output logic        data_bready_o,

	output logic        rf_wen_o,
	output logic [4:0]  rf_waddr_o,
	output logic [31:0] rf_wdata_o,
	output logic        commit_o,
	output logic [31:0] commit_pc_o,
	output logic        retire_valid_o,
	output logic [31:0] retire_pc_o,
	output logic [4:0]  retire_rd_o,
	output logic [31:0] retire_wdata_o,
	output logic        halt_o
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_READ,
		S_WRITE,
		S_RESP
	} state_e;

	state_e      state_q;
	logic        fin;
	logic        fin_err;
	logic [31:0] fin_data;

	// instruction finishes this cycle
	always_comb begin
		fin      = 1'b0;
		fin_err  = 1'b0;
		fin_data = m.result;
		case (state_q)
			S_IDLE: fin = m.valid && (m.mem_op == MEM_NONE);
			S_READ: begin
				fin      = data_rvalid_i && data_rready_o;
				fin_err  = (data_rresp_i != RESP_OKAY);
				fin_data = data_rdata_i;
			end
			S_RESP: begin
				fin     = data_bvalid_i;
				fin_err = (data_bresp_i != RESP_OKAY);
			end
			default: fin = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst_i) begin
			state_q            <= S_IDLE;
			data_raddr_valid_o <= 1'b0;
			data_waddr_valid_o <= 1'b0;
			data_wvalid_o      <= 1'b0;
			retire_valid_o     <= 1'b0;
			commit_o           <= 1'b0;
			rf_wen_o           <= 1'b0;
			halt_o             <= 1'b0;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (m.valid && m.mem_op == MEM_LOAD) begin
						data_raddr_valid_o <= 1'b1;
						state_q            <= S_READ;
					end else if (m.valid && m.mem_op == MEM_STORE) begin
						data_waddr_valid_o <= 1'b1;
						data_wvalid_o      <= 1'b1;
						state_q            <= S_WRITE;
					end
				end
				S_READ: begin
					if (data_raddr_ready_i)
						data_raddr_valid_o <= 1'b0;
					if (fin)
						state_q <= S_IDLE;
				end
				S_WRITE: begin
					// address and data may complete in either order
					if (data_waddr_ready_i)
						data_waddr_valid_o <= 1'b0;
					if (data_wready_i)
						data_wvalid_o <= 1'b0;
					if ((!data_waddr_valid_o || data_waddr_ready_i) &&
						(!data_wvalid_o || data_wready_i))
						state_q <= S_RESP;
				end
				default: begin
					if (fin)
						state_q <= S_IDLE;
				end
			endcase
			retire_valid_o <= fin && !fin_err;
			commit_o       <= fin && !fin_err && !m.halt;
			rf_wen_o       <= fin && !fin_err && m.wen;
			// sticky until reset
			if (fin && (fin_err || m.halt))
				halt_o <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (fin) begin
			retire_pc_o    <= m.pc;
			retire_rd_o    <= m.wen ? m.rd : 5'd0;
			retire_wdata_o <= (m.wen && m.rd != 5'd0) ? fin_data : 32'd0;
			commit_pc_o    <= m.next_pc;
		end
	end

	assign data_raddr_o  = m.result;
	assign data_waddr_o  = m.result;
	assign data_wdata_o  = m.store_data;
	assign data_rready_o = (state_q == S_READ) && !data_raddr_valid_o;
	assign data_bready_o = (state_q == S_RESP);
	assign rf_waddr_o    = retire_rd_o;
	assign rf_wdata_o    = retire_wdata_o;

	// execute holds the store operand until commit
	a_wdata_stable: assert property (@(posedge clock) disable iff (rst_i)
		data_wvalid_o && !data_wready_i |=> data_wvalid_o && $stable(data_wdata_o));

endmodule

`default_nettype wire

// File: design/rv_core.sv
`default_nettype none

module rv_core import rv_pkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  wire         clock,
	input  wire         rst_i,

	// instruction bus
	output logic [31:0] inst_addr_o,
	output logic        inst_addr_valid_o,
	input  wire         inst_addr_ready_i,
	input  wire  [31:0] inst_data_i,
	input  wire  [1:0]  inst_resp_i,
	input  wire         inst_valid_i,
	output logic        inst_ready_o,

	// data bus
	output logic [31:0] data_raddr_o,
	output logic        data_raddr_valid_o,
	input  wire         data_raddr_ready_i,
	input  wire  [31:0] data_rdata_i,
	input  wire  [1:0]  data_rresp_i,
	input  wire         data_rvalid_i,
	output logic        data_rready_o,
	output logic [31:0] data_waddr_o,
	output logic        data_waddr_valid_o,
	input  wire         data_waddr_ready_i,
	output logic [31:0] data_wdata_o,
	output logic        data_wvalid_o,
	input  wire         data_wready_i,
	input  wire  [1:0]  data_bresp_i,
	input  wire         data_bvalid_i,
	output logic        data_bready_o,

	// commit trace
	output logic        retire_valid_o,
	output logic [31:0] retire_pc_o,
	output logic [4:0]  retire_rd_o,
	output logic [31:0] retire_wdata_o,
	output logic        halt_o
);

	logic        commit;
	logic [31:0] commit_pc;
	logic [4:0]  raddr1;
	logic [4:0]  raddr2;
	logic [31:0] rdata1;
	logic [31:0] rdata2;
	logic        dec_valid;
	rv_dec_t     dec;
	logic [31:0] dec_pc;
	logic [31:0] dec_rs1;
	logic [31:0] dec_rs2;
	logic        rf_wen;
	logic [4:0]  rf_waddr;
	logic [31:0] rf_wdata;

	fetch_if   fetch_bus ();
	mem_req_if req_bus ();

	rv_fetch #(
		.RESET_PC (RESET_PC)
	) u_fetch (
		.clock             (clock),
		.rst_i             (rst_i),
		.inst_addr_o       (inst_addr_o),
		.inst_addr_valid_o (inst_addr_valid_o),
		.inst_addr_ready_i (inst_addr_ready_i),
		.inst_data_i       (inst_data_i),
		.inst_resp_i       (inst_resp_i),
		.inst_valid_i      (inst_valid_i),
		.inst_ready_o      (inst_ready_o),
		.commit_i          (commit),
		.commit_pc_i       (commit_pc),
		.halt_i            (halt_o),
		.f                 (fetch_bus)
	);

	rv_decode u_decode (
		.clock       (clock),
		.rst_i       (rst_i),
		.f           (fetch_bus),
		.raddr1_o    (raddr1),
		.raddr2_o    (raddr2),
		.rdata1_i    (rdata1),
		.rdata2_i    (rdata2),
		.dec_valid_o (dec_valid),
		.dec_o       (dec),
		.pc_o        (dec_pc),
		.rs1_o       (dec_rs1),
		.rs2_o       (dec_rs2)
	);

	rv_regfile u_regfile (
		.clock    (clock),
		.rst_i    (rst_i),
		.raddr1_i (raddr1),
		.raddr2_i (raddr2),
		.wen_i    (rf_wen),
		.waddr_i  (rf_waddr),
		.wdata_i  (rf_wdata),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2)
	);

	rv_execute u_execute (
		.clock       (clock),
		.rst_i       (rst_i),
		.dec_valid_i (dec_valid),
		.dec_i       (dec),
		.pc_i        (dec_pc),
		.rs1_i       (dec_rs1),
		.rs2_i       (dec_rs2),
		.m           (req_bus)
	);

	rv_lsu u_lsu (
		.clock              (clock),
		.rst_i              (rst_i),
		.m                  (req_bus),
		.data_raddr_o       (data_raddr_o),
		.data_raddr_valid_o (data_raddr_valid_o),
		.data_raddr_ready_i (data_raddr_ready_i),
		.data_rdata_i       (data_rdata_i),
		.data_rresp_i       (data_rresp_i),
		.data_rvalid_i      (data_rvalid_i),
		.data_rready_o      (data_rready_o),
		.data_waddr_o       (data_waddr_o),
		.data_waddr_valid_o (data_waddr_valid_o),
		.data_waddr_ready_i (data_waddr_ready_i),
		.data_wdata_o       (data_wdata_o),
		.data_wvalid_o      (data_wvalid_o),
		.data_wready_i      (data_wready_i),
		.data_bresp_i       (data_bresp_i),
		.data_bvalid_i      (data_bvalid_i),
		.data_bready_o      (data_bready_o),
		.rf_wen_o           (rf_wen),
		.rf_waddr_o         (rf_waddr),
		.rf_wdata_o         (rf_wdata),
		.commit_o           (commit),
		.commit_pc_o        (commit_pc),
		.retire_valid_o     (retire_valid_o),
		.retire_pc_o        (retire_pc_o),
		.retire_rd_o        (retire_rd_o),
		.retire_wdata_o     (retire_wdata_o),
		.halt_o             (halt_o)
	);

endmodule

`default_nettype wire

// File: testbench/rv_checker.sv
`default_nettype none

module rv_checker (
	input  wire        clock,
	input  wire        rst_i,
	input  wire        retire_valid_i,
	input  wire [31:0] retire_pc_i,
	input  wire [4:0]  retire_rd_i,
	input  wire [31:0] retire_wdata_i,
	input  wire        halt_i,
	input  wire        inst_addr_valid_i,
	input  wire [31:0] waddr_i,
	input  wire        waddr_valid_i,
	input  wire        waddr_ready_i,
	input  wire [31:0] wdata_i,
	input  wire        wvalid_i,
	input  wire        wready_i
);

	int mismatches = 0;
	int failures = 0;

	logic [8*24-1:0] test_name;
	logic [31:0]     exp_pc[$];
	logic [4:0]      exp_rd[$];
	logic [31:0]     exp_val[$];
	logic [31:0]     exp_st_addr[$];
	logic [31:0]     exp_st_data[$];
	// write channels complete independently
	logic [31:0]     aw_q[$];
	logic [31:0]     w_q[$];
	logic            halt_q = 1'b0;

	task automatic start_test(input logic [8*24-1:0] name);
		test_name = name;
		exp_pc.delete();
		exp_rd.delete();
		exp_val.delete();
		exp_st_addr.delete();
		exp_st_data.delete();
		aw_q.delete();
		w_q.delete();
	endtask

	task automatic expect_retire(input logic [31:0] pc, input logic [4:0] rd,
		input logic [31:0] val);
		exp_pc.push_back(pc);
		exp_rd.push_back(rd);
		exp_val.push_back(val);
	endtask

	task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
		exp_st_addr.push_back(addr);
		exp_st_data.push_back(data);
	endtask

	task automatic close_test();
		if (exp_pc.size() != 0) begin
			$display("%0s: %0d expected retire records never appeared", test_name,
				exp_pc.size());
			failures++;
		end
		if (exp_st_addr.size() != 0) begin
			$display("%0s: %0d expected stores never appeared", test_name,
				exp_st_addr.size());
			failures++;
		end
		if (aw_q.size() != 0 || w_q.size() != 0) begin
			$display("%0s: write address and write data counts do not match", test_name);
			failures++;
		end
	endtask

	always @(negedge clock) begin
		if (rst_i) begin
			halt_q = 1'b0;
		end else begin
			if (halt_q && retire_valid_i) begin
				$display("%0s: retire at pc %h after halt", test_name, retire_pc_i);
				failures++;
			end
			if (halt_q && inst_addr_valid_i) begin
				$display("%0s: instruction fetch started after halt", test_name);
				failures++;
			end
			halt_q = halt_i;

			if (retire_valid_i) begin
				if (exp_pc.size() == 0) begin
					$display("%0s: unexpected extra retire at pc %h", test_name, retire_pc_i);
					failures++;
				end else begin
					if (retire_pc_i != exp_pc[0] || retire_rd_i != exp_rd[0] ||
						retire_wdata_i != exp_val[0]) begin
						$write("Mismatch %0s retire: expected pc=%h rd=%0d data=%h",
							test_name, exp_pc[0], exp_rd[0], exp_val[0]);
						$display(", actual pc=%h rd=%0d data=%h", retire_pc_i, retire_rd_i,
							retire_wdata_i);
						mismatches++;
					end
					void'(exp_pc.pop_front());
					void'(exp_rd.pop_front());
					void'(exp_val.pop_front());
				end
			end

			if (waddr_valid_i && waddr_ready_i)
				aw_q.push_back(waddr_i);
			if (wvalid_i && wready_i)
				w_q.push_back(wdata_i);
			while (aw_q.size() != 0 && w_q.size() != 0) begin
				if (exp_st_addr.size() == 0) begin
					$display("%0s: unexpected extra store to %h", test_name, aw_q[0]);
					failures++;
				end else begin
					if (aw_q[0] != exp_st_addr[0] || w_q[0] != exp_st_data[0]) begin
						$write("Mismatch %0s store: expected addr=%h data=%h",
							test_name, exp_st_addr[0], exp_st_data[0]);
						$display(", actual addr=%h data=%h", aw_q[0], w_q[0]);
						mismatches++;
					end
					void'(exp_st_addr.pop_front());
					void'(exp_st_data.pop_front());
				end
				void'(aw_q.pop_front());
				void'(w_q.pop_front());
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/tb_rv_core.sv
`default_nettype none

module tb_rv_core;

	logic        clock;
	logic        rst_i;
	logic [31:0] inst_addr_o;
	logic        inst_addr_valid_o;
	logic        inst_addr_ready_i;
	logic [31:0] inst_data_i;
	logic [1:0]  inst_resp_i;
	logic        inst_valid_i;
	logic        inst_ready_o;
	logic [31:0] data_raddr_o;
	logic        data_raddr_valid_o;
	logic        data_raddr_ready_i;
	logic [31:0] data_rdata_i;
	logic [1:0]  data_rresp_i;
	logic        data_rvalid_i;
	logic        data_rready_o;
	logic [31:0] data_waddr_o;
	logic        data_waddr_valid_o;
	logic        data_waddr_ready_i;
	logic [31:0] data_wdata_o;
	logic        data_wvalid_o;
	logic        data_wready_i;
	logic [1:0]  data_bresp_i;
	logic        data_bvalid_i;
	logic        data_bready_o;
	logic        retire_valid_o;
	logic [31:0] retire_pc_o;
	logic [4:0]  retire_rd_o;
	logic [31:0] retire_wdata_o;
	logic        halt_o;

	// stimulus records, each tagged with its test index
	logic [8*24-1:0] names[$];
	int              prog_t[$];
	logic [31:0]     prog_a[$];
	logic [31:0]     prog_d[$];
	int              data_t[$];
	logic [31:0]     data_a[$];
	logic [31:0]     data_d[$];
	int              err_t[$];
	logic [31:0]     err_a[$];
	int              ret_t[$];
	logic [31:0]     ret_pc[$];
	logic [4:0]      ret_rd[$];
	logic [31:0]     ret_val[$];
	int              st_t[$];
	logic [31:0]     st_a[$];
	logic [31:0]     st_d[$];

	logic [31:0] imem[logic [31:0]];
	logic [31:0] dmem[logic [31:0]];
	logic        errs[logic [31:0]];

	int cycles = 0;
	int limit = 0;

	rv_core #(
		.RESET_PC (32'h0)
	) DUT (.*);

	rv_checker chk (
		.clock             (clock),
		.rst_i             (rst_i),
		.retire_valid_i    (retire_valid_o),
		.retire_pc_i       (retire_pc_o),
		.retire_rd_i       (retire_rd_o),
		.retire_wdata_i    (retire_wdata_o),
		.halt_i            (halt_o),
		.inst_addr_valid_i (inst_addr_valid_o),
		.waddr_i           (data_waddr_o),
		.waddr_valid_i     (data_waddr_valid_o),
		.waddr_ready_i     (data_waddr_ready_i),
		.wdata_i           (data_wdata_o),
		.wvalid_i          (data_wvalid_o),
		.wready_i          (data_wready_i)
	);

	always #2 clock = ~clock;

	function automatic logic [31:0] read_inst(input logic [31:0] a);
		return imem.exists(a) ? imem[a] : (a ^ 32'h3c96_5a0f);
	endfunction

	function automatic logic [31:0] read_data(input logic [31:0] a);
		return dmem.exists(a) ? dmem[a] : (a ^ 32'ha5c3_0f1e);
	endfunction

	function automatic logic [1:0] resp_for(input logic [31:0] a);
		return errs.exists(a) ? 2'b10 : 2'b00;
	endfunction

	task automatic after_edge();
		@(posedge clock);
		#1;
	endtask

	task automatic random_gap();
		int unsigned gap;
		gap = $urandom_range(3);
		repeat (gap) after_edge();
	endtask

	// instruction bus memory
	always begin : inst_bus
		logic        hs;
		logic [31:0] a;
		hs = 1'b0;
		while (!hs) begin
			@(negedge clock);
			hs = inst_addr_valid_o && inst_addr_ready_i;
			a = inst_addr_o;
			after_edge();
			inst_addr_ready_i = hs ? 1'b0 : ($urandom_range(2) == 0);
		end
		random_gap();
		inst_data_i = read_inst(a);
		inst_resp_i = resp_for(a);
		inst_valid_i = 1'b1;
		hs = 1'b0;
		while (!hs) begin
			@(negedge clock);
			hs = inst_ready_o;
			after_edge();
		end
		inst_valid_i = 1'b0;
	end

	// data read channels
	always begin : read_bus
		logic        hs;
		logic [31:0] a;
		hs = 1'b0;
		while (!hs) begin
			@(negedge clock);
			hs = data_raddr_valid_o && data_raddr_ready_i;
			a = data_raddr_o;
			after_edge();
			data_raddr_ready_i = hs ? 1'b0 : ($urandom_range(2) == 0);
		end
		random_gap();
		data_rdata_i = read_data(a);
		data_rresp_i = resp_for(a);
		data_rvalid_i = 1'b1;
		hs = 1'b0;
		while (!hs) begin
			@(negedge clock);
			hs = data_rready_o;
			after_edge();
		end
		data_rvalid_i = 1'b0;
	end

	// data write channels, address and data taken in any order
	always begin : write_bus
		logic        aw_done;
		logic        w_done;
		logic        aw_hs;
		logic        w_hs;
		logic [31:0] a;
		logic [31:0] d;
		aw_done = 1'b0;
		w_done = 1'b0;
		while (!(aw_done && w_done)) begin
			@(negedge clock);
			aw_hs = data_waddr_valid_o && data_waddr_ready_i;
			w_hs = data_wvalid_o && data_wready_i;
			if (aw_hs)
				a = data_waddr_o;
			if (w_hs)
				d = data_wdata_o;
			after_edge();
			if (aw_hs)
				aw_done = 1'b1;
			if (w_hs)
				w_done = 1'b1;
			data_waddr_ready_i = aw_done ? 1'b0 : ($urandom_range(2) == 0);
			data_wready_i = w_done ? 1'b0 : ($urandom_range(2) == 0);
		end
		if (!errs.exists(a))
			dmem[a] = d;
		random_gap();
		data_bresp_i = resp_for(a);
		data_bvalid_i = 1'b1;
		aw_hs = 1'b0;
		while (!aw_hs) begin
			@(negedge clock);
			aw_hs = data_bready_o;
			after_edge();
		end
		data_bvalid_i = 1'b0;
	end

	always @(posedge clock) begin
		cycles++;
		if (limit != 0 && cycles > limit) begin
			$display("timeout after %0d cycles, the core stopped making progress", cycles);
			$display("errors: %0d mismatches, %0d other failures, 1 timeout",
				chk.mismatches, chk.failures);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic read_stimulus();
		int              fd;
		int              code;
		int              t;
		logic [8*24-1:0] tok;
		logic [8*24-1:0] name;
		logic [8*80-1:0] line;
		logic [31:0]     x;
		logic [31:0]     y;
		logic [31:0]     z;
		t = -1;
		fd = $fopen("testbench/rv_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file");
			chk.failures++;
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%s", tok);
				if (code != 1)
					break;
				if (tok == "#") begin
					code = $fgets(line, fd);
				end else if (tok == "test") begin
					code = $fscanf(fd, "%s", name);
					names.push_back(name);
					t++;
				end else if (tok == "prog") begin
					code = $fscanf(fd, "%h %h", x, y);
					prog_t.push_back(t);
					prog_a.push_back(x);
					prog_d.push_back(y);
				end else if (tok == "data") begin
					code = $fscanf(fd, "%h %h", x, y);
					data_t.push_back(t);
					data_a.push_back(x);
					data_d.push_back(y);
				end else if (tok == "err") begin
					code = $fscanf(fd, "%h", x);
					err_t.push_back(t);
					err_a.push_back(x);
				end else if (tok == "ret") begin
					code = $fscanf(fd, "%h %h %h", x, y, z);
					ret_t.push_back(t);
					ret_pc.push_back(x);
					ret_rd.push_back(y[4:0]);
					ret_val.push_back(z);
				end else if (tok == "st") begin
					code = $fscanf(fd, "%h %h", x, y);
					st_t.push_back(t);
					st_a.push_back(x);
					st_d.push_back(y);
				end else begin
					$display("unknown keyword %0s in the stimulus file", tok);
					chk.failures++;
				end
			end
			$fclose(fd);
			if (names.size() == 0) begin
				$display("the stimulus file holds no tests");
				chk.failures++;
			end
		end
	endtask

	task automatic run_test(input int t);
		imem.delete();
		dmem.delete();
		errs.delete();
		foreach (prog_t[i])
			if (prog_t[i] == t)
				imem[prog_a[i]] = prog_d[i];
		foreach (data_t[i])
			if (data_t[i] == t)
				dmem[data_a[i]] = data_d[i];
		foreach (err_t[i])
			if (err_t[i] == t)
				errs[err_a[i]] = 1'b1;
		chk.start_test(names[t]);
		foreach (ret_t[i])
			if (ret_t[i] == t)
				chk.expect_retire(ret_pc[i], ret_rd[i], ret_val[i]);
		foreach (st_t[i])
			if (st_t[i] == t)
				chk.expect_store(st_a[i], st_d[i]);
		after_edge();
		rst_i = 1'b1;
		repeat (2) after_edge();
		rst_i = 1'b0;
		// every test ends in a halt
		do
			@(negedge clock);
		while (!halt_o);
		repeat (10) after_edge();
		chk.close_test();
	endtask

	initial begin
		int unsigned seed_val;
		clock = 1'b0;
		rst_i = 1'b1;
		inst_addr_ready_i = 1'b0;
		inst_data_i = 32'd0;
		inst_resp_i = 2'b00;
		inst_valid_i = 1'b0;
		data_raddr_ready_i = 1'b0;
		data_rdata_i = 32'd0;
		data_rresp_i = 2'b00;
		data_rvalid_i = 1'b0;
		data_waddr_ready_i = 1'b0;
		data_wready_i = 1'b0;
		data_bresp_i = 2'b00;
		data_bvalid_i = 1'b0;
		seed_val = $urandom(32'h39fd8e99);
		read_stimulus();
		// reset and drain take about 20 cycles per test
		limit = 40 * (ret_t.size() + st_t.size()) + 20 * names.size();
		foreach (names[t])
			run_test(t);
		$display("errors: %0d mismatches, %0d other failures, 0 timeouts",
			chk.mismatches, chk.failures);
		if (chk.mismatches == 0 && chk.failures == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/rv_stimulus.txt
# test <name> / prog <addr> <word> / data <addr> <word> / err <addr>
# ret <pc> <rd> <value> / st <addr> <data>, all numbers hex
test arith
prog 00 00500093
prog 04 ffd00113
prog 08 002081b3
prog 0c 40208233
prog 10 0020f2b3
prog 14 0020e333
prog 18 0020c3b3
prog 1c 00112433
prog 20 fff0a493
prog 24 12345537
prog 28 7ff54593
prog 2c 00100073
ret 00 01 00000005
ret 04 02 fffffffd
ret 08 03 00000002
ret 0c 04 00000008
ret 10 05 00000005
ret 14 06 fffffffd
ret 18 07 fffffff8
ret 1c 08 00000001
ret 20 09 00000000
ret 24 0a 12345000
ret 28 0b 123457ff
ret 2c 00 00000000
test mem
prog 00 10000093
prog 04 0000a103
prog 08 07700193
prog 0c 0030a223
prog 10 0040a203
prog 14 0020a423
prog 18 004102b3
prog 1c 00100073
data 100 cafef00d
ret 00 01 00000100
ret 04 02 cafef00d
ret 08 03 00000077
ret 0c 00 00000000
ret 10 04 00000077
ret 14 00 00000000
ret 18 05 cafef084
ret 1c 00 00000000
st 104 00000077
st 108 cafef00d
test branch
prog 00 00100093
prog 04 00200113
prog 08 00208463
prog 0c 0020c463
prog 10 00900193
prog 14 00109463
prog 18 008002ef
prog 1c 00900193
prog 20 00114463
prog 24 00100073
ret 00 01 00000001
ret 04 02 00000002
ret 08 00 00000000
ret 0c 00 00000000
ret 14 00 00000000
ret 18 05 0000001c
ret 20 00 00000000
ret 24 00 00000000
test zero_reg
prog 00 00700013
prog 04 000000b3
prog 08 00100073
ret 00 00 00000000
ret 04 01 00000000
ret 08 00 00000000
test load_error
prog 00 20000093
prog 04 0000a103
err 200
ret 00 01 00000200
test store_error
prog 00 20000093
prog 04 0010a023
err 200
ret 00 01 00000200
st 200 00000200

// File: rv_core.f
design/rv_pkg.sv
design/rv_if.sv
design/rv_fetch.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_lsu.sv
design/rv_core.sv
testbench/rv_checker.sv
testbench/tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_rv_core
FILELIST  := rv_core.f
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
